// File: verilog/cache_bank_pkg.sv
package cache_bank_pkg;

    // address and line geometry
    localparam int ADDR_WIDTH  = 16;
    localparam int WORD_WIDTH  = 32;
    localparam int OFFSET_BITS = 2;
    localparam int INDEX_BITS  = 4;
    localparam int NUM_SET     = 16;
    localparam int NUM_WAY     = 2;
    localparam int TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS;

    // requester id carried through to the return
    localparam int PORT_BITS   = 2;

    // access sequencing states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        HIT_RETURN,
        MISS_REQUEST,
        MISS_WAIT,
        MISS_RETURN,
        RELEASE
    } bank_state_t;

endpackage

// File: verilog/bank_ctrl.sv
`timescale 1ns/10ps

module bank_ctrl
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    input  logic                                  access_valid,
    input  logic [cache_bank_pkg::ADDR_WIDTH-1:0] access_addr,
    input  logic [cache_bank_pkg::PORT_BITS-1:0]  access_port,
    output logic                                  access_ack,

    output logic                                  return_valid,
    output logic [cache_bank_pkg::WORD_WIDTH-1:0] return_data,
    output logic [cache_bank_pkg::ADDR_WIDTH-1:0] return_addr,
    output logic [cache_bank_pkg::PORT_BITS-1:0]  return_port,
    input  logic                                  return_ack,

    output logic                                  miss_valid,
    output logic [cache_bank_pkg::ADDR_WIDTH-1:0] miss_addr,
    input  logic                                  miss_ack,

    input  logic                                  fetch_valid,
    input  logic [cache_bank_pkg::WORD_WIDTH-1:0] fetch_data,
    output logic                                  fetch_ack,

    output logic [cache_bank_pkg::INDEX_BITS-1:0] set_index,
    output logic                                  read_en,
    output logic                                  refill_en,
    output logic                                  refill_way,
    output logic [cache_bank_pkg::TAG_BITS-1:0]   refill_tag,
    output logic [cache_bank_pkg::WORD_WIDTH-1:0] refill_data,
    output logic                                  touch_en,
    output logic                                  touch_way,

    input  logic                                  hit,
    input  logic                                  hit_way,
    input  logic [cache_bank_pkg::NUM_WAY-1:0]    way_valid,
    input  logic                                  victim_way,
    input  logic [cache_bank_pkg::WORD_WIDTH-1:0] read_word
);

    localparam int INDEX_LO = cache_bank_pkg::OFFSET_BITS;
    localparam int TAG_LO   = cache_bank_pkg::OFFSET_BITS + cache_bank_pkg::INDEX_BITS;

    cache_bank_pkg::bank_state_t state;

    logic                                  issue_grant;
    logic                                  fill_way;
    logic                                  return_done;
    logic [cache_bank_pkg::ADDR_WIDTH-1:0] req_addr;
    logic [cache_bank_pkg::PORT_BITS-1:0]  req_port;

    // bank stays locked from acceptance until RELEASE
    assign issue_grant = access_valid & (state == cache_bank_pkg::IDLE);

    assign return_valid = (state == cache_bank_pkg::HIT_RETURN) ||
                          (state == cache_bank_pkg::MISS_RETURN);
    assign return_done  = return_valid & return_ack;
    assign return_addr  = req_addr;
    assign return_port  = req_port;

    assign miss_valid = (state == cache_bank_pkg::MISS_REQUEST);
    assign miss_addr  = {req_addr[cache_bank_pkg::ADDR_WIDTH-1:INDEX_LO],
                         {cache_bank_pkg::OFFSET_BITS{1'b0}}};

    assign fetch_ack = (state == cache_bank_pkg::MISS_WAIT) & fetch_valid;

    assign set_index   = req_addr[TAG_LO-1:INDEX_LO];
    assign read_en     = (state == cache_bank_pkg::LOOKUP);
    assign refill_tag  = req_addr[cache_bank_pkg::ADDR_WIDTH-1:TAG_LO];
    assign refill_data = fetch_data;
    assign refill_en   = fetch_ack;

    // empty way before the lru way
    assign fill_way   = ~way_valid[0] ? 1'b0 :
                        ~way_valid[1] ? 1'b1 : victim_way;
    assign refill_way = fill_way;

    // recency moves on a hit or a refill
    assign touch_en  = ((state == cache_bank_pkg::COMPARE) & hit) | refill_en;
    assign touch_way = (state == cache_bank_pkg::COMPARE) ? hit_way : fill_way;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            state      <= cache_bank_pkg::IDLE;
            access_ack <= 1'b0;
        end
        else
        begin
            access_ack <= return_done;
            case (state)
                cache_bank_pkg::IDLE:
                begin
                    if (issue_grant)
                        state <= cache_bank_pkg::LOOKUP;
                end
                cache_bank_pkg::LOOKUP:
                    state <= cache_bank_pkg::COMPARE;
                cache_bank_pkg::COMPARE:
                    state <= hit ? cache_bank_pkg::HIT_RETURN : cache_bank_pkg::MISS_REQUEST;
                cache_bank_pkg::HIT_RETURN:
                begin
                    if (return_ack)
                        state <= cache_bank_pkg::RELEASE;
                end
                cache_bank_pkg::MISS_REQUEST:
                begin
                    if (miss_ack)
                        state <= cache_bank_pkg::MISS_WAIT;
                end
                cache_bank_pkg::MISS_WAIT:
                begin
                    if (fetch_valid)
                        state <= cache_bank_pkg::MISS_RETURN;
                end
                cache_bank_pkg::MISS_RETURN:
                begin
                    if (return_ack)
                        state <= cache_bank_pkg::RELEASE;
                end
                cache_bank_pkg::RELEASE:
                    state <= cache_bank_pkg::IDLE;
                default:
                    state <= cache_bank_pkg::IDLE;
            endcase
        end
    end

    // request fields and returned word
    always_ff @(posedge clk_in)
    begin
        if (issue_grant)
        begin
            req_addr <= access_addr;
            req_port <= access_port;
        end
        if ((state == cache_bank_pkg::COMPARE) && hit)
            return_data <= read_word;
        else if (fetch_ack)
            return_data <= fetch_data;
    end

endmodule

// File: verilog/tag_store.sv
`timescale 1ns/10ps

module tag_store
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    input  logic [cache_bank_pkg::INDEX_BITS-1:0] set_index,
    input  logic                                  read_en,
    input  logic [cache_bank_pkg::TAG_BITS-1:0]   lookup_tag,

    input  logic                                  refill_en,
    input  logic                                  refill_way,
    input  logic [cache_bank_pkg::TAG_BITS-1:0]   refill_tag,

    output logic                                  hit,
    output logic                                  hit_way,
    output logic [cache_bank_pkg::NUM_WAY-1:0]    way_valid
);

    logic [cache_bank_pkg::NUM_WAY-1:0][cache_bank_pkg::NUM_SET-1:0] valid_bits;
    logic [cache_bank_pkg::TAG_BITS-1:0] tag_mem [cache_bank_pkg::NUM_WAY][cache_bank_pkg::NUM_SET];
    logic [cache_bank_pkg::TAG_BITS-1:0] rd_tag  [cache_bank_pkg::NUM_WAY];
    logic [cache_bank_pkg::NUM_WAY-1:0]  rd_valid;
    logic [cache_bank_pkg::NUM_WAY-1:0]  match;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            valid_bits <= '0;
            rd_valid   <= '0;
        end
        else
        begin
            if (refill_en)
                valid_bits[refill_way][set_index] <= 1'b1;
            if (read_en)
            begin
                for (int w = 0; w < cache_bank_pkg::NUM_WAY; w++)
                    rd_valid[w] <= valid_bits[w][set_index];
            end
        end
    end

    always_ff @(posedge clk_in)
    begin
        if (refill_en)
            tag_mem[refill_way][set_index] <= refill_tag;
        if (read_en)
        begin
            for (int w = 0; w < cache_bank_pkg::NUM_WAY; w++)
                rd_tag[w] <= tag_mem[w][set_index];
        end
    end

    // compare only counts for a valid entry
    always_comb
    begin
        for (int w = 0; w < cache_bank_pkg::NUM_WAY; w++)
            match[w] = rd_valid[w] && (rd_tag[w] == lookup_tag);
    end

    assign hit       = |match;
    assign hit_way   = match[1];
    assign way_valid = rd_valid;

endmodule

// File: verilog/data_store.sv
`timescale 1ns/10ps

module data_store
(
    input  logic                                  clk_in,

    input  logic [cache_bank_pkg::INDEX_BITS-1:0] set_index,
    input  logic                                  read_en,
    input  logic                                  select_way,

    input  logic                                  refill_en,
    input  logic                                  refill_way,
    input  logic [cache_bank_pkg::WORD_WIDTH-1:0] refill_data,

    output logic [cache_bank_pkg::WORD_WIDTH-1:0] read_word
);

    logic [cache_bank_pkg::WORD_WIDTH-1:0] word_mem [cache_bank_pkg::NUM_WAY][cache_bank_pkg::NUM_SET];
    logic [cache_bank_pkg::WORD_WIDTH-1:0] rd_word  [cache_bank_pkg::NUM_WAY];

    // both ways read together, way picked after the tag compare
    always_ff @(posedge clk_in)
    begin
        if (refill_en)
            word_mem[refill_way][set_index] <= refill_data;
        if (read_en)
        begin
            for (int w = 0; w < cache_bank_pkg::NUM_WAY; w++)
                rd_word[w] <= word_mem[w][set_index];
        end
    end

    assign read_word = rd_word[select_way];

endmodule

// File: verilog/replace_history.sv
`timescale 1ns/10ps

module replace_history
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    input  logic [cache_bank_pkg::INDEX_BITS-1:0] set_index,
    input  logic                                  read_en,

    input  logic                                  touch_en,
    input  logic                                  touch_way,

    output logic                                  victim_way
);

    // one bit per set naming the lru way
    logic [cache_bank_pkg::NUM_SET-1:0] lru_bits;
    logic                               victim_reg;

    always_ff @(posedge clk_in or posedge reset_in)
    begin
        if (reset_in)
        begin
            lru_bits   <= '0;
            victim_reg <= 1'b0;
        end
        else
        begin
            // touched way becomes mru
            if (touch_en)
                lru_bits[set_index] <= ~touch_way;
            if (read_en)
                victim_reg <= lru_bits[set_index];
        end
    end

    assign victim_way = victim_reg;

endmodule

// File: verilog/cache_bank_top.sv
`timescale 1ns/10ps

module cache_bank_top
(
    input  logic                                  clk_in,
    input  logic                                  reset_in,

    input  logic                                  access_valid,
    input  logic [cache_bank_pkg::ADDR_WIDTH-1:0] access_addr,
    input  logic [cache_bank_pkg::PORT_BITS-1:0]  access_port,
    output logic                                  access_ack,

    output logic                                  return_valid,
    output logic [cache_bank_pkg::WORD_WIDTH-1:0] return_data,
    output logic [cache_bank_pkg::ADDR_WIDTH-1:0] return_addr,
    output logic [cache_bank_pkg::PORT_BITS-1:0]  return_port,
    input  logic                                  return_ack,

    output logic                                  miss_valid,
    output logic [cache_bank_pkg::ADDR_WIDTH-1:0] miss_addr,
    input  logic                                  miss_ack,

    input  logic                                  fetch_valid,
    input  logic [cache_bank_pkg::WORD_WIDTH-1:0] fetch_data,
    output logic                                  fetch_ack
);

    logic [cache_bank_pkg::INDEX_BITS-1:0] set_index;
    logic                                  read_en;
    logic                                  refill_en;
    logic                                  refill_way;
    logic [cache_bank_pkg::TAG_BITS-1:0]   refill_tag;
    logic [cache_bank_pkg::WORD_WIDTH-1:0] refill_data;
    logic                                  touch_en;
    logic                                  touch_way;
    logic                                  hit;
    logic                                  hit_way;
    logic [cache_bank_pkg::NUM_WAY-1:0]    way_valid;
    logic                                  victim_way;
    logic [cache_bank_pkg::WORD_WIDTH-1:0] read_word;

    bank_ctrl ctrl
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .access_valid (access_valid),
        .access_addr  (access_addr),
        .access_port  (access_port),
        .access_ack   (access_ack),
        .return_valid (return_valid),
        .return_data  (return_data),
        .return_addr  (return_addr),
        .return_port  (return_port),
        .return_ack   (return_ack),
        .miss_valid   (miss_valid),
        .miss_addr    (miss_addr),
        .miss_ack     (miss_ack),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_ack    (fetch_ack),
        .set_index    (set_index),
        .read_en      (read_en),
        .refill_en    (refill_en),
        .refill_way   (refill_way),
        .refill_tag   (refill_tag),
        .refill_data  (refill_data),
        .touch_en     (touch_en),
        .touch_way    (touch_way),
        .hit          (hit),
        .hit_way      (hit_way),
        .way_valid    (way_valid),
        .victim_way   (victim_way),
        .read_word    (read_word)
    );

    // lookup and refill share the latched request tag
    tag_store tags
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .set_index  (set_index),
        .read_en    (read_en),
        .lookup_tag (refill_tag),
        .refill_en  (refill_en),
        .refill_way (refill_way),
        .refill_tag (refill_tag),
        .hit        (hit),
        .hit_way    (hit_way),
        .way_valid  (way_valid)
    );

    data_store data
    (
        .clk_in      (clk_in),
        .set_index   (set_index),
        .read_en     (read_en),
        .select_way  (hit_way),
        .refill_en   (refill_en),
        .refill_way  (refill_way),
        .refill_data (refill_data),
        .read_word   (read_word)
    );

    replace_history history
    (
        .clk_in     (clk_in),
        .reset_in   (reset_in),
        .set_index  (set_index),
        .read_en    (read_en),
        .touch_en   (touch_en),
        .touch_way  (touch_way),
        .victim_way (victim_way)
    );

endmodule

// File: bench/cache_bank_tb.sv
`timescale 1ns/10ps

module cache_bank_tb;

    logic                                  clk_in;
    logic                                  reset_in;
    logic                                  access_valid;
    logic [cache_bank_pkg::ADDR_WIDTH-1:0] access_addr;
    logic [cache_bank_pkg::PORT_BITS-1:0]  access_port;
    logic                                  access_ack;
    logic                                  return_valid;
    logic [cache_bank_pkg::WORD_WIDTH-1:0] return_data;
    logic [cache_bank_pkg::ADDR_WIDTH-1:0] return_addr;
    logic [cache_bank_pkg::PORT_BITS-1:0]  return_port;
    logic                                  return_ack;
    logic                                  miss_valid;
    logic [cache_bank_pkg::ADDR_WIDTH-1:0] miss_addr;
    logic                                  miss_ack;
    logic                                  fetch_valid;
    logic [cache_bank_pkg::WORD_WIDTH-1:0] fetch_data;
    logic                                  fetch_ack;

    // stimulus table with one entry per access
    logic [cache_bank_pkg::ADDR_WIDTH-1:0] row_addr [$];
    logic [cache_bank_pkg::PORT_BITS-1:0]  row_port [$];
    bit                                    row_hit  [$];
    logic [cache_bank_pkg::WORD_WIDTH-1:0] row_data [$];

    int          error_count = 0;
    int          check_count = 0;
    int unsigned lcg_state   = 24760;

    cache_bank_top uut
    (
        .clk_in       (clk_in),
        .reset_in     (reset_in),
        .access_valid (access_valid),
        .access_addr  (access_addr),
        .access_port  (access_port),
        .access_ack   (access_ack),
        .return_valid (return_valid),
        .return_data  (return_data),
        .return_addr  (return_addr),
        .return_port  (return_port),
        .return_ack   (return_ack),
        .miss_valid   (miss_valid),
        .miss_addr    (miss_addr),
        .miss_ack     (miss_ack),
        .fetch_valid  (fetch_valid),
        .fetch_data   (fetch_data),
        .fetch_ack    (fetch_ack)
    );

    initial
    begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;
    end

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // back-pressure of 0 to 5 cycles
    function automatic int pick_delay();
        return (next_random() >> 16) % 6;
    endfunction

    // downstream memory contents as a function of the block address
    function automatic logic [cache_bank_pkg::WORD_WIDTH-1:0] fill_word(
        input logic [cache_bank_pkg::ADDR_WIDTH-1:0] block_addr);
        return {block_addr, ~block_addr};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            $display("FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
            error_count++;
        end
    endtask

    task automatic report_problem(input string what);
        $display("ERROR: %s at %0t", what, $time);
        error_count++;
    endtask

    task automatic add_row(input logic [15:0] addr, input logic [1:0] port,
                           input bit hit, input logic [31:0] data);
        row_addr.push_back(addr);
        row_port.push_back(port);
        row_hit.push_back(hit);
        row_data.push_back(data);
    endtask

    task automatic load_table();
        // cold miss then hit in set 13
        add_row(16'h1236, 2'd1, 1'b0, 32'h1234_edcb);
        add_row(16'h1234, 2'd2, 1'b1, 32'h1234_edcb);
        // tags A, B and C all in set 3
        add_row(16'h040c, 2'd0, 1'b0, 32'h040c_fbf3);
        add_row(16'h080d, 2'd3, 1'b0, 32'h080c_f7f3);
        add_row(16'h040e, 2'd1, 1'b1, 32'h040c_fbf3);
        add_row(16'h080c, 2'd2, 1'b1, 32'h080c_f7f3);
        add_row(16'h040c, 2'd0, 1'b1, 32'h040c_fbf3);
        // C evicts B as the lru way
        add_row(16'h0c0c, 2'd3, 1'b0, 32'h0c0c_f3f3);
        add_row(16'h040c, 2'd1, 1'b1, 32'h040c_fbf3);
        add_row(16'h080c, 2'd2, 1'b0, 32'h080c_f7f3);
        add_row(16'h1237, 2'd0, 1'b1, 32'h1234_edcb);
    endtask

    // one access from request to access_ack sampled 3 ns after each edge
    task automatic run_row(input int r);
        int   cyc;
        int   ret_cycle;
        int   ret_end;
        int   fetch_cycle;
        int   wait_count;
        int   miss_delay;
        int   fetch_delay;
        int   ret_delay;
        int   errors_before;
        bit   saw_miss;
        bit   miss_done;
        bit   fetch_done;
        bit   ret_done;
        bit   done;
        bit   next_miss_ack;
        bit   next_fetch_valid;
        bit   next_return_ack;
        logic [cache_bank_pkg::WORD_WIDTH-1:0] held_data;
        logic [cache_bank_pkg::ADDR_WIDTH-1:0] held_addr;
        logic [cache_bank_pkg::ADDR_WIDTH-1:0] held_miss;
        logic [cache_bank_pkg::PORT_BITS-1:0]  held_port;
        errors_before = error_count;
        miss_delay    = pick_delay();
        fetch_delay   = pick_delay();
        ret_delay     = pick_delay();
        cyc = 0;
        ret_cycle = -1;
        ret_end = -1;
        fetch_cycle = -1;
        wait_count = 0;
        saw_miss = 1'b0;
        miss_done = 1'b0;
        fetch_done = 1'b0;
        ret_done = 1'b0;
        done = 1'b0;
        next_miss_ack = 1'b0;
        next_fetch_valid = 1'b0;
        next_return_ack = 1'b0;
        held_miss = '0;
        @(posedge clk_in);
        #1;
        access_valid = 1'b1;
        access_addr  = row_addr[r];
        access_port  = row_port[r];
        while (!done)
        begin
            #2;
            if (miss_valid)
            begin
                if (miss_done)
                    report_problem("miss_valid held after the miss handshake");
                if (!saw_miss)
                begin
                    saw_miss  = 1'b1;
                    held_miss = miss_addr;
                    if (row_hit[r])
                        report_problem("miss request on an access that should hit");
                    check_value("miss_addr", miss_addr, row_addr[r] & 16'hfffc);
                    check_value("miss_valid cycle", cyc, 3);
                end
                else
                    check_value("miss_addr", miss_addr, held_miss);
                if (miss_ack)
                begin
                    miss_done     = 1'b1;
                    next_miss_ack = 1'b0;
                    wait_count    = 0;
                end
                else if (wait_count == miss_delay)
                    next_miss_ack = 1'b1;
                else
                    wait_count++;
            end
            else if (miss_done && !fetch_done)
            begin
                check_value("fetch_ack", fetch_ack, fetch_valid);
                if (fetch_valid && fetch_ack)
                begin
                    fetch_done       = 1'b1;
                    fetch_cycle      = cyc;
                    next_fetch_valid = 1'b0;
                end
                else if (wait_count == fetch_delay)
                    next_fetch_valid = 1'b1;
                else
                    wait_count++;
            end
            if (return_valid)
            begin
                if (ret_done)
                    report_problem("return_valid held after the return handshake");
                if (ret_cycle < 0)
                begin
                    ret_cycle  = cyc;
                    wait_count = 0;
                    held_data  = return_data;
                    held_addr  = return_addr;
                    held_port  = return_port;
                    check_value("return_data", return_data, row_data[r]);
                    check_value("return_addr", return_addr, row_addr[r]);
                    check_value("return_port", return_port, row_port[r]);
                end
                else
                begin
                    check_value("return_data", return_data, held_data);
                    check_value("return_addr", return_addr, held_addr);
                    check_value("return_port", return_port, held_port);
                end
                check_value("access_ack", access_ack, 1'b0);
                if (return_ack)
                begin
                    ret_done        = 1'b1;
                    ret_end         = cyc;
                    next_return_ack = 1'b0;
                end
                else if (wait_count == ret_delay)
                    next_return_ack = 1'b1;
                else
                    wait_count++;
            end
            else if (access_ack)
            begin
                if (!ret_done)
                    report_problem("access acknowledged before the return handshake");
                else
                    check_value("access_ack cycle", cyc, ret_end + 1);
                done = 1'b1;
            end
            if (!done)
            begin
                @(posedge clk_in);
                #1;
                miss_ack   = next_miss_ack;
                return_ack = next_return_ack;
                if (next_fetch_valid && !fetch_valid)
                    fetch_data = fill_word(held_miss);
                fetch_valid = next_fetch_valid;
                cyc++;
            end
        end
        if (row_hit[r])
            check_value("return_valid cycle", ret_cycle, 3);
        else if (!saw_miss)
            report_problem("no miss request on an access that should miss");
        else
            check_value("return_valid cycle", ret_cycle, fetch_cycle + 1);
        @(posedge clk_in);
        #1;
        access_valid = 1'b0;
        $display("row %0d addr %h port %0d %s: %0d mismatches", r, row_addr[r],
                 row_port[r], row_hit[r] ? "hit" : "miss", error_count - errors_before);
    endtask

    initial
    begin
        reset_in     = 1'b1;
        access_valid = 1'b0;
        access_addr  = '0;
        access_port  = '0;
        return_ack   = 1'b0;
        miss_ack     = 1'b0;
        fetch_valid  = 1'b0;
        fetch_data   = '0;
        load_table();
        repeat (5) @(posedge clk_in);
        #1;
        reset_in = 1'b0;
        #2;
        check_value("access_ack", access_ack, 1'b0);
        check_value("return_valid", return_valid, 1'b0);
        check_value("miss_valid", miss_valid, 1'b0);
        check_value("fetch_ack", fetch_ack, 1'b0);
        for (int r = 0; r < row_addr.size(); r++)
            run_row(r);
        $display("%0d rows, %0d checks, %0d errors", row_addr.size(), check_count, error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

    // watchdog sized from the table length
    initial
    begin
        @(negedge reset_in);
        repeat (row_addr.size() * 40) @(posedge clk_in);
        $display("ERROR: timeout, an access never completed within %0d cycles",
                 row_addr.size() * 40);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: cache_bank.f
verilog/cache_bank_pkg.sv
verilog/bank_ctrl.sv
verilog/tag_store.sv
verilog/data_store.sv
verilog/replace_history.sv
verilog/cache_bank_top.sv
bench/cache_bank_tb.sv
